// File: Makefile
TOP = heapTb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "test failed" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: design/arrayTable.sv
// Array table
// Per-array size and allocation flag, stack of freed arrays, next new array number

`timescale 1ns/1ps

module arrayTable #(
  parameter int addressBits = heapPkg::defaultAddressBits,
  parameter int indexBits   = heapPkg::defaultIndexBits
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [addressBits-1:0] tableArray,                 // Array to look up or update
  input  logic                   sizeLoad,
  input  logic [indexBits:0]     sizeValue,
  input  logic                   allocStrobe,
  input  logic                   freeStrobe,
  output logic [indexBits:0]     tableSize,                  // Registered lookup
  output logic                   tableAllocated,
  output logic                   tableEverAllocated,
  output logic [addressBits-1:0] allocResult,                // Array the next alloc gets
  output logic                   allocFail
);

  localparam int arrayCount = 2 ** addressBits;

  logic [indexBits:0]     sizes [arrayCount];
  logic [addressBits-1:0] freedStack [arrayCount];            // LIFO of freed arrays
  logic [arrayCount-1:0]  allocated;
  logic [addressBits:0]   freedTop;                          // Entries on the stack
  logic [addressBits:0]   everCount;                         // Arrays ever handed out
  logic [addressBits:0]   topIndex;

  assign topIndex    = freedTop - 1'b1;
  assign allocResult = freedTop != '0 ? freedStack[topIndex[addressBits-1:0]]
                                      : everCount[addressBits-1:0];
  assign allocFail   = freedTop == '0 && everCount == (addressBits+1)'(arrayCount);

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocated <= '0;
      freedTop  <= '0;
      everCount <= '0;
    end else if (allocStrobe) begin
      allocated[allocResult] <= 1'b1;
      if (freedTop != '0) freedTop <= topIndex;              // Reuse latest freed first
      else everCount <= everCount + 1'b1;                    // Fresh array number
    end else if (freeStrobe) begin
      allocated[tableArray] <= 1'b0;
      freedTop              <= freedTop + 1'b1;
    end
  end

  // ----------------------------------------
  // Sizes, freed stack and lookup
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (allocStrobe) sizes[allocResult] <= '0;               // New array starts empty
    else if (sizeLoad) sizes[tableArray] <= sizeValue;
    if (freeStrobe) freedStack[freedTop[addressBits-1:0]] <= tableArray;
    tableSize          <= sizes[tableArray];
    tableAllocated     <= allocated[tableArray];
    tableEverAllocated <= {1'b0, tableArray} < everCount;
  end

endmodule

// File: design/elementStore.sv
// Element store for all arrays
// One synchronous read port, one write port, in-place add and subtract

`timescale 1ns/1ps

module elementStore #(
  parameter int addressBits = heapPkg::defaultAddressBits,
  parameter int indexBits   = heapPkg::defaultIndexBits,
  parameter int dataBits    = heapPkg::defaultDataBits
) (
  input  logic                   clock,
  input  logic [addressBits-1:0] addrArray,                  // Array number
  input  logic [indexBits-1:0]   addrIndex,                  // Element within array
  input  logic                   write,
  input  logic [dataBits-1:0]    writeData,
  input  logic [1:0]             arith,                      // Bit 0 add, bit 1 subtract
  output logic [dataBits-1:0]    readData                    // One cycle after address
);

  localparam int depth = 2 ** (addressBits + indexBits);    // One fixed block per array

  logic [dataBits-1:0]                  memory [depth];
  logic [addressBits+indexBits-1:0]     address;
  logic [dataBits-1:0]                  newValue;

  assign address = {addrArray, addrIndex};

  // ----------------------------------------
  // Value to store
  // ----------------------------------------
  // readData holds the element read last cycle at the same address
  always_comb begin
    if (arith[0])      newValue = readData + writeData;       // Wraps at dataBits
    else if (arith[1]) newValue = readData - writeData;
    else               newValue = writeData;
  end

  // ----------------------------------------
  // Memory and read register
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (write) begin
      memory[address] <= newValue;
      readData        <= newValue;                           // Write first so read shows new value
    end else begin
      readData        <= memory[address];
    end
  end

endmodule

// File: design/heapControl.sv
// Heap command controller
// Captures a command, checks the array, sequences store and scan, returns result

`timescale 1ns/1ps

module heapControl #(
  parameter int addressBits = heapPkg::defaultAddressBits,
  parameter int indexBits   = heapPkg::defaultIndexBits,
  parameter int dataBits    = heapPkg::defaultDataBits
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req,
  input  heapPkg::heapOp         op,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  input  logic [indexBits:0]     tableSize,                  // Lookup one cycle after address
  input  logic                   tableAllocated,
  input  logic                   tableEverAllocated,
  input  logic [addressBits-1:0] allocResult,
  input  logic                   allocFail,
  input  logic [dataBits-1:0]    readData,
  input  logic [indexBits-1:0]   scanIndex,
  input  logic                   scanDone,
  input  logic [indexBits:0]     scanResult,
  output logic                   ack,
  output logic [dataBits-1:0]    dataOut,
  output heapPkg::heapError      error,
  output logic [addressBits-1:0] tableArray,
  output logic                   sizeLoad,
  output logic [indexBits:0]     sizeValue,
  output logic                   allocStrobe,
  output logic                   freeStrobe,
  output logic [addressBits-1:0] storeAddrArray,
  output logic [indexBits-1:0]   storeAddrIndex,
  output logic                   storeWrite,
  output logic [dataBits-1:0]    storeWriteData,
  output logic [1:0]             storeArith,                 // Bit 0 add, bit 1 subtract
  output logic                   scanStart
);
  import heapPkg::*;

  localparam logic [indexBits:0] fullSize = (indexBits+1)'(2 ** indexBits);

  typedef enum logic [2:0] {stIdle, stCheck, stArith, stFetch, stScan, stRespond} ctrlState;

  ctrlState               state;
  heapOp                  capOp;                             // Captured command
  logic [addressBits-1:0] capArray;
  logic [indexBits-1:0]   capIndex;
  logic [dataBits-1:0]    capData;
  heapError               checkError;
  logic                   checkOk;
  logic [indexBits:0]     lastIndex;                         // size-1 for pop
  logic                   isScan;

  // ----------------------------------------
  // Checks, in priority order
  // ----------------------------------------
  always_comb begin
    checkError = errNone;
    if (capOp == opAlloc) begin
      if (allocFail) checkError = errOutOfMemory;
    end else if (!tableEverAllocated) checkError = errUnallocated;
    else if (!tableAllocated) checkError = errFreed;
    else begin
      case (capOp)
        opRead, opAdd, opSubtract: if ({1'b0, capIndex} >= tableSize) checkError = errBounds;
        opPush: if (tableSize == fullSize) checkError = errFull;
        opPop:  if (tableSize == '0) checkError = errEmpty;
        default: checkError = errNone;
      endcase
    end
  end

  assign checkOk   = state == stCheck && checkError == errNone;
  assign lastIndex = tableSize - 1'b1;
  assign isScan    = capOp inside {opLess, opGreater, opIndex};

  // Lookup on the live inputs in idle so results are ready in check
  assign tableArray     = state == stIdle ? array : capArray;
  assign allocStrobe    = checkOk && capOp == opAlloc;
  assign freeStrobe     = checkOk && capOp == opFree;
  assign scanStart      = checkOk && isScan;
  assign sizeLoad       = checkOk && (capOp == opPush || capOp == opPop ||
                          (capOp == opWrite && {1'b0, capIndex} >= tableSize));
  assign sizeValue      = capOp == opPush ? tableSize + 1'b1 :
                          capOp == opPop  ? lastIndex : {1'b0, capIndex} + 1'b1;
  assign storeAddrArray = capArray;
  assign storeAddrIndex = state == stScan   ? scanIndex :
                          capOp == opPush  ? tableSize[indexBits-1:0] :
                          capOp == opPop   ? lastIndex[indexBits-1:0] : capIndex;
  assign storeWrite     = (checkOk && (capOp == opWrite || capOp == opPush)) || state == stArith;
  assign storeWriteData = capData;
  assign storeArith     = state == stArith ? {capOp == opSubtract, capOp == opAdd} : 2'b00;

  // ----------------------------------------
  // Sequencing and result
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= stIdle;
      ack     <= 1'b0;
      dataOut <= '0;
      error   <= errNone;
    end else begin
      case (state)
        stIdle: if (req) state <= stCheck;                   // Command captured below
        stCheck: begin
          error <= checkError;
          state <= stRespond;                                // Most commands finish here
          ack   <= 1'b1;
          if (checkError == errNone) begin
            case (capOp)
              opWrite, opPush: dataOut <= capData;
              opSize:  dataOut <= dataBits'(tableSize);
              opAlloc: dataOut <= dataBits'(allocResult);
              opRead, opPop: begin
                ack   <= 1'b0;
                state <= stFetch;
              end
              opAdd, opSubtract: begin
                ack   <= 1'b0;
                state <= stArith;
              end
              opLess, opGreater, opIndex: begin
                ack   <= 1'b0;
                state <= stScan;
              end
              default: dataOut <= dataOut;                   // Free returns no value
            endcase
          end
        end
        stArith: state <= stFetch;                           // Write back then show new value
        stFetch: begin
          dataOut <= readData;
          ack     <= 1'b1;
          state   <= stRespond;
        end
        stScan: if (scanDone) begin
          dataOut <= dataBits'(scanResult);
          ack     <= 1'b1;
          state   <= stRespond;
        end
        default: if (!req) begin                             // Hold until host lets go
          ack   <= 1'b0;
          state <= stIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stIdle) begin
      capOp    <= op;
      capArray <= array;
      capIndex <= index;
      capData  <= dataIn;
    end
  end

endmodule

// File: design/heapMemory.sv
// Heap memory top level
// Command controller plus element store, array table and scan unit

`timescale 1ns/1ps

module heapMemory #(
  parameter int addressBits = heapPkg::defaultAddressBits,   // Array number width
  parameter int indexBits   = heapPkg::defaultIndexBits,     // Element index width
  parameter int dataBits    = heapPkg::defaultDataBits       // Element width
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req,                        // Host command request
  input  heapPkg::heapOp         op,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  output logic                   ack,                        // Result valid
  output logic [dataBits-1:0]    dataOut,
  output heapPkg::heapError      error
);

  logic [addressBits-1:0] tableArray;                        // Array under lookup
  logic [indexBits:0]     tableSize;
  logic                   tableAllocated;
  logic                   tableEverAllocated;
  logic [addressBits-1:0] allocResult;
  logic                   allocFail;
  logic                   sizeLoad;
  logic [indexBits:0]     sizeValue;
  logic                   allocStrobe;
  logic                   freeStrobe;
  logic [addressBits-1:0] storeAddrArray;                    // Element store port
  logic [indexBits-1:0]   storeAddrIndex;
  logic                   storeWrite;
  logic [dataBits-1:0]    storeWriteData;
  logic [1:0]             storeArith;
  logic [dataBits-1:0]    readData;
  logic                   scanStart;                         // Scan unit port
  logic [indexBits-1:0]   scanIndex;
  logic                   scanDone;
  logic [indexBits:0]     scanResult;

  heapControl #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    control (.*);

  elementStore #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    store (
      .clock     (clock),
      .addrArray (storeAddrArray),
      .addrIndex (storeAddrIndex),
      .write     (storeWrite),
      .writeData (storeWriteData),
      .arith     (storeArith),
      .readData  (readData)
    );

  arrayTable #(.addressBits(addressBits), .indexBits(indexBits))
    table0 (.*);

  // Host holds op and dataIn until ack, so the scan reads them directly
  searchUnit #(.indexBits(indexBits), .dataBits(dataBits))
    search (
      .clock      (clock),
      .reset      (reset),
      .scanStart  (scanStart),
      .mode       (op),
      .key        (dataIn),
      .size       (tableSize),
      .readData   (readData),
      .scanIndex  (scanIndex),
      .scanDone   (scanDone),
      .scanResult (scanResult)
    );

endmodule

// File: design/heapPkg.sv
// Heap of fixed size arrays
// Shared command and result encodings plus default sizing

package heapPkg;

  // ----------------------------------------
  // Commands accepted over the req/ack handshake
  // ----------------------------------------
  typedef enum logic [3:0] {
    opWrite    = 4'd0,                         // Write an element, grow size if needed
    opRead     = 4'd1,                         // Read an element
    opSize     = 4'd2,                         // Current size of array
    opPush     = 4'd3,                         // Append at the end
    opPop      = 4'd4,                         // Remove from the end
    opAdd      = 4'd5,                         // Add in place, return new value
    opSubtract = 4'd6,                         // Subtract in place, return new value
    opLess     = 4'd7,                         // Count elements below key
    opGreater  = 4'd8,                         // Count elements above key
    opIndex    = 4'd9,                         // Last matching position plus one
    opAlloc    = 4'd10,                        // Hand out an array
    opFree     = 4'd11                         // Return an array
  } heapOp;

  // ----------------------------------------
  // Result codes, one per command
  // ----------------------------------------
  typedef enum logic [2:0] {
    errNone        = 3'd0,                     // Command succeeded
    errUnallocated = 3'd1,                     // Array never handed out
    errFreed       = 3'd2,                     // Array was freed
    errBounds      = 3'd3,                     // Index at or past size
    errFull        = 3'd4,                     // Push onto full array
    errEmpty       = 3'd5,                     // Pop from empty array
    errOutOfMemory = 3'd6                      // No array left to allocate
  } heapError;

  localparam int defaultAddressBits = 2;       // Four arrays
  localparam int defaultIndexBits   = 3;       // Eight elements per array
  localparam int defaultDataBits    = 12;      // Element width

endpackage

// File: design/searchUnit.sv
// Sequential array scan, one element per clock
// Counts elements below or above a key, or finds the last matching position

`timescale 1ns/1ps

module searchUnit #(
  parameter int indexBits = heapPkg::defaultIndexBits,
  parameter int dataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 scanStart,
  input  heapPkg::heapOp       mode,                         // Less, greater or index
  input  logic [dataBits-1:0]  key,
  input  logic [indexBits:0]   size,                         // Elements to walk
  input  logic [dataBits-1:0]  readData,                     // Element at compareIndex
  output logic [indexBits-1:0] scanIndex,
  output logic                 scanDone,                     // Pulses size+2 cycles after start
  output logic [indexBits:0]   scanResult
);
  import heapPkg::*;

  logic               active;
  logic               compareValid;                          // readData is a live element
  logic [indexBits:0] walkIndex;
  logic [indexBits:0] compareIndex;
  logic               hit;

  assign scanIndex = walkIndex[indexBits-1:0];

  always_comb begin
    case (mode)
      opLess:    hit = readData < key;                       // Unsigned compare
      opGreater: hit = readData > key;
      default:   hit = readData == key;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      active       <= 1'b0;
      compareValid <= 1'b0;
      scanDone     <= 1'b0;
      walkIndex    <= '0;
      scanResult   <= '0;
    end else begin
      scanDone     <= 1'b0;
      compareValid <= active && walkIndex != size;
      if (scanStart) begin
        active     <= 1'b1;
        walkIndex  <= '0;
        scanResult <= '0;
      end else if (active && walkIndex == size) begin
        active   <= 1'b0;                                    // Last compare lands with done
        scanDone <= 1'b1;
      end else if (active) walkIndex <= walkIndex + 1'b1;
      if (compareValid && hit)
        scanResult <= mode == opIndex ? compareIndex + 1'b1 : scanResult + 1'b1;
    end
  end

  always_ff @(posedge clock) compareIndex <= walkIndex;      // Matches readData latency

endmodule

// File: files.f
design/heapPkg.sv
design/elementStore.sv
design/arrayTable.sv
design/searchUnit.sv
design/heapControl.sv
design/heapMemory.sv
testbench/heapMemory_sva.sv
testbench/heapChecker.sv
testbench/heapTb.sv

// File: testbench/heapChecker.sv
// Heap memory response checker
// Model of arrays, sizes, flags and freed stack checked on every ack

`timescale 1ns/1ps

module heapChecker #(
  parameter int addressBits = heapPkg::defaultAddressBits,
  parameter int indexBits   = heapPkg::defaultIndexBits,
  parameter int dataBits    = heapPkg::defaultDataBits
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req,
  input  heapPkg::heapOp         op,
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    dataIn,
  input  logic                   ack,
  input  logic [dataBits-1:0]    dataOut,
  input  heapPkg::heapError      error,
  input  int                     testId,
  input  logic                   testEnd,                    // Print the test line
  output int                     totalChecks = 0,
  output int                     totalErrors = 0
);
  import heapPkg::*;

  localparam int arrayCount = 2 ** addressBits;
  localparam int capacity   = 2 ** indexBits;
  localparam int mask       = (1 << dataBits) - 1;

  int   mem [arrayCount][capacity];                          // Model element values
  int   sizes [arrayCount];
  bit   allocated [arrayCount];
  int   everCount = 0;
  int   freedStack [$];                                      // Back is the latest freed
  logic ackPrev = 1'b0;
  int   testChecks = 0;
  int   testErrors = 0;

  function automatic string testName(input int id);
    case (id)
      0: return "preload";
      1: return "allocation";
      2: return "write/read/size";
      3: return "push/pop";
      4: return "add/subtract";
      5: return "scans";
      6: return "misuse";
      default: return "unknown";
    endcase
  endfunction

  // ----------------------------------------
  // Model of one command
  // ----------------------------------------
  task automatic applyCommand(input heapOp cmd, input int a, input int i, input int d,
                              output heapError expErr, output int expData);
    expErr  = errNone;
    expData = 0;
    if (cmd == opAlloc) begin
      if (freedStack.size() > 0) expData = freedStack.pop_back();  // Reuse latest freed
      else if (everCount < arrayCount) begin
        expData = everCount;
        everCount++;
      end else expErr = errOutOfMemory;
      if (expErr == errNone) begin
        allocated[expData] = 1'b1;
        sizes[expData]     = 0;
      end
    end else if (a >= everCount) expErr = errUnallocated;
    else if (!allocated[a]) expErr = errFreed;
    else begin
      case (cmd)
        opWrite: begin
          mem[a][i] = d;
          if (i >= sizes[a]) sizes[a] = i + 1;
          expData = d;
        end
        opRead: if (i >= sizes[a]) expErr = errBounds;
          else expData = mem[a][i];
        opSize: expData = sizes[a];
        opPush: if (sizes[a] == capacity) expErr = errFull;
          else begin
            mem[a][sizes[a]] = d;
            sizes[a]++;
            expData = d;
          end
        opPop: if (sizes[a] == 0) expErr = errEmpty;
          else begin
            sizes[a]--;
            expData = mem[a][sizes[a]];
          end
        opAdd, opSubtract: if (i >= sizes[a]) expErr = errBounds;
          else begin
            mem[a][i] = (cmd == opAdd ? mem[a][i] + d : mem[a][i] - d) & mask;  // Wraps
            expData   = mem[a][i];
          end
        opLess, opGreater, opIndex:
          for (int k = 0; k < sizes[a]; k++) begin
            if (cmd == opLess && mem[a][k] < d) expData++;
            if (cmd == opGreater && mem[a][k] > d) expData++;
            if (cmd == opIndex && mem[a][k] == d) expData = k + 1;  // Last match wins
          end
        default: begin                                       // Free
          allocated[a] = 1'b0;
          freedStack.push_back(a);
        end
      endcase
    end
  endtask

  // ----------------------------------------
  // Compare on each rising ack
  // ----------------------------------------
  always @(posedge clock) begin
    heapError expErr;
    int       expData;
    if (reset) begin
      for (int a = 0; a < arrayCount; a++) allocated[a] = 1'b0;
      everCount = 0;
      freedStack.delete();                                   // Memory itself survives reset
      ackPrev = 1'b0;
    end else begin
      if (ack && !ackPrev) begin
        testChecks++;
        totalChecks++;
        if (!req) begin
          $display("Error in %s: ack rose with no request pending", testName(testId));
          testErrors++;
          totalErrors++;
        end else begin
          applyCommand(op, int'(array), int'(index), int'(dataIn), expErr, expData);
          if (error !== expErr) begin
            $display("Error in %s: %s result expected %s actual %s", testName(testId),
                     op.name(), expErr.name(), error.name());
            testErrors++;
            totalErrors++;
          end else if (expErr == errNone && op != opFree &&
                       dataOut !== dataBits'(expData)) begin
            $display("Error in %s: %s data expected %0d actual %0d", testName(testId),
                     op.name(), expData, int'(dataOut));
            testErrors++;
            totalErrors++;
          end
        end
      end
      ackPrev = ack;
    end
    if (testEnd) begin
      $display("%s: %0d checks, %0d errors", testName(testId), testChecks, testErrors);
      testChecks = 0;
      testErrors = 0;
    end
  end

endmodule

// File: testbench/heapMemory_sva.sv
// Handshake assertions for the heap memory
// Bound into the top level, watches req/ack and the command inputs

`timescale 1ns/1ps

module heapMemorySva #(
  parameter int addressBits = heapPkg::defaultAddressBits,
  parameter int indexBits   = heapPkg::defaultIndexBits,
  parameter int dataBits    = heapPkg::defaultDataBits
) (
  input logic                   clock,
  input logic                   reset,
  input logic                   req,
  input heapPkg::heapOp         op,
  input logic [addressBits-1:0] array,
  input logic [indexBits-1:0]   index,
  input logic [dataBits-1:0]    dataIn,
  input logic                   ack
);

  ackNeedsReq: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> req) else $error("ack rose while req was low");

  inputsHeld: assert property (@(posedge clock) disable iff (reset)
    req && !ack && $past(req) && !$past(ack) |->
      $stable(op) && $stable(array) && $stable(index) && $stable(dataIn))
    else $error("command inputs changed before ack");

  ackDrops: assert property (@(posedge clock) disable iff (reset)
    !req && !$past(req) && !$past(req, 2) |-> !ack) else $error("ack held after req fell");

endmodule

// File: testbench/heapTb.sv
// Heap memory testbench
// Clock, reset, seeded random command driver, timeout and final verdict

`timescale 1ns/1ps

module heapTb;
  import heapPkg::*;

  localparam int addressBits = defaultAddressBits;
  localparam int indexBits   = defaultIndexBits;
  localparam int dataBits    = defaultDataBits;
  localparam int capacity    = 2 ** indexBits;
  // Commands issued per test
  localparam int preloadCount   = 4 + 4 * capacity;
  localparam int allocCount     = 11;
  localparam int rwCount        = 40;
  localparam int fillDrainCount = 2 * (capacity + 1);
  localparam int pushPopCount   = 60;
  localparam int arithCount     = 40;
  localparam int scanCount      = 56;
  localparam int misuseCount    = 36 + capacity;
  localparam int totalCommands  = preloadCount + allocCount + rwCount + fillDrainCount +
                                  pushPopCount + arithCount + scanCount + misuseCount;
  localparam int cycleLimit     = totalCommands * (capacity + 12);  // Worst case per command

  logic                   clock = 1'b0;
  logic                   reset = 1'b1;
  logic                   req = 1'b0;
  heapOp                  op = opSize;
  logic [addressBits-1:0] array = '0;
  logic [indexBits-1:0]   index = '0;
  logic [dataBits-1:0]    dataIn = '0;
  logic                   ack;
  logic [dataBits-1:0]    dataOut;
  heapError               error;
  int                     testId = 0;                        // Test in progress
  logic                   testEnd = 1'b0;
  int                     totalChecks;
  int                     totalErrors;
  int                     cycles = 0;

  heapMemory #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    heapMemory_inst (.*);

  heapChecker #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    responseCheck (.*);

  bind heapMemory heapMemorySva #(.addressBits(addressBits), .indexBits(indexBits),
    .dataBits(dataBits)) handshakeSva (.clock(clock), .reset(reset), .req(req), .op(op),
    .array(array), .index(index), .dataIn(dataIn), .ack(ack));

  always #10 clock = ~clock;                                 // 20 ns period

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: DUT stopped answering after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Driver tasks
  // ----------------------------------------
  task automatic sendCommand(input heapOp cmd, input int arr, input int idx, input int data);
    @(posedge clock);
    #2;
    op     = cmd;
    array  = addressBits'(arr);
    index  = indexBits'(idx);
    dataIn = dataBits'(data);
    req    = 1'b1;
    @(posedge clock);
    while (!ack) @(posedge clock);                          // Variable latency
    #2 req = 1'b0;
    while (ack) @(posedge clock);                           // Four-phase return
  endtask

  task automatic applyReset();
    @(posedge clock);
    #2 reset = 1'b1;
    repeat (5) @(posedge clock);
    #2 reset = 1'b0;
  endtask

  task automatic finishTest(input int id);
    @(posedge clock);
    #2;
    testId  = id;
    testEnd = 1'b1;
    @(posedge clock);
    #2 testEnd = 1'b0;
    testId  = id + 1;
  endtask

  function automatic int fillValue(input int a, input int i);
    return ((a * capacity + i) * 181 + 23) % (1 << dataBits);  // Whole address mixed in
  endfunction

  function automatic int randomBelow(input int n);
    return int'($urandom % n);
  endfunction

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int k;
    void'($urandom(88946));                                  // Single seed for the run
    repeat (5) @(posedge clock);
    #2 reset = 1'b0;
    for (int a = 0; a < 4; a++) sendCommand(opAlloc, 0, 0, 0);  // Preload every element
    for (int a = 0; a < 4; a++)
      for (int i = 0; i < capacity; i++) sendCommand(opWrite, a, i, fillValue(a, i));
    finishTest(0);
    applyReset();                                            // Memory keeps its contents
    for (int n = 0; n < 5; n++) sendCommand(opAlloc, 0, 0, 0);  // Fifth is out of memory
    sendCommand(opFree, 1, 0, 0);
    sendCommand(opFree, 3, 0, 0);
    sendCommand(opAlloc, 0, 0, 0);                           // Expect 3 then 1
    sendCommand(opAlloc, 0, 0, 0);
    sendCommand(opSize, 3, 0, 0);
    sendCommand(opSize, 1, 0, 0);
    finishTest(1);
    for (int n = 0; n < rwCount; n++) begin
      k = randomBelow(3);
      sendCommand(k == 0 ? opWrite : k == 1 ? opRead : opSize, randomBelow(4),
                  randomBelow(capacity), randomBelow(1 << dataBits));
    end
    finishTest(2);
    for (int n = 0; n <= capacity; n++) sendCommand(opPop, 0, 0, 0);  // Drain past empty
    for (int n = 0; n <= capacity; n++)                      // Fill past full
      sendCommand(opPush, 1, 0, randomBelow(1 << dataBits));
    for (int n = 0; n < pushPopCount; n++) begin
      k = randomBelow(6);                                    // Push 3, pop 2, size 1
      sendCommand(k < 3 ? opPush : k < 5 ? opPop : opSize, randomBelow(2), 0,
                  randomBelow(1 << dataBits));
    end
    finishTest(3);
    for (int n = 0; n < arithCount; n++) begin
      k = randomBelow(5);
      sendCommand(k < 2 ? opAdd : k < 4 ? opSubtract : opRead, randomBelow(4),
                  randomBelow(capacity), randomBelow(1 << dataBits));
    end
    finishTest(4);
    for (int n = 0; n < 16; n++)                             // Small values so keys match
      sendCommand(opWrite, randomBelow(4), randomBelow(capacity), randomBelow(8));
    for (int n = 0; n < 40; n++) begin
      k = randomBelow(3);
      sendCommand(k == 0 ? opLess : k == 1 ? opGreater : opIndex, randomBelow(4), 0,
                  randomBelow(8));
    end
    finishTest(5);
    applyReset();
    sendCommand(opAlloc, 0, 0, 0);
    sendCommand(opAlloc, 0, 0, 0);
    sendCommand(opFree, 1, 0, 0);                            // Arrays 2 and 3 never allocated
    sendCommand(opFree, 1, 0, 0);                            // Second free of the same array
    for (int n = 0; n < 30; n++) begin
      k = randomBelow(11);
      sendCommand(k == 10 ? opFree : heapOp'(4'(k)), 1 + randomBelow(3),
                  randomBelow(capacity), randomBelow(1 << dataBits));
    end
    sendCommand(opAlloc, 0, 0, 0);                           // Freed stack holds array 1 once
    sendCommand(opAlloc, 0, 0, 0);
    sendCommand(opWrite, 1, capacity - 1, randomBelow(1 << dataBits));  // Grow to full size
    for (int i = 0; i < capacity - 1; i++) sendCommand(opRead, 1, i, 0);  // Contents untouched
    finishTest(6);
    @(posedge clock);
    $display("Totals: %0d checks, %0d errors", totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
